// File: uart_pkg.sv
package uart_pkg;

    // Payload and timing types
    typedef logic [7:0]  frame_t;
    typedef logic [15:0] baud_div_t;
    typedef logic [3:0]  dlen_t;
    typedef logic [7:0]  offset_t;

    // Register byte offsets
    localparam offset_t DR_OFFSET  = 8'h00;
    localparam offset_t CR_OFFSET  = 8'h04;
    localparam offset_t SR_OFFSET  = 8'h08;
    localparam offset_t BRR_OFFSET = 8'h0C;
    localparam offset_t IER_OFFSET = 8'h10;

    // Control register fields
    localparam int CR_PE       = 0;
    localparam int CR_TE       = 1;
    localparam int CR_RE       = 2;
    localparam int CR_STOP2    = 4;
    localparam int CR_DLEN_LSB = 8;
    localparam int CR_DLEN_MSB = 11;

    // Status bits, shared with the interrupt enable register
    localparam int SR_TBE   = 0;
    localparam int SR_RBF   = 1;
    localparam int SR_OVR   = 2;
    localparam int SR_WIDTH = 3;

    // Reset values
    localparam baud_div_t BRR_RESET = 16'd16;
    localparam logic [SR_WIDTH-1:0] SR_RESET = SR_WIDTH'(1) << SR_TBE;

endpackage

// File: uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic                seq,
    input  logic                rst,
    input  uart_pkg::baud_div_t baud_div,
    input  uart_pkg::dlen_t     dlen,
    input  logic                stop2,
    input  logic                tx_start,
    input  uart_pkg::frame_t    tx_data,
    output logic                tx_busy,
    output logic                tx
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t state;
    baud_div_t timer;
    dlen_t     bit_idx;
    logic      stop_second;
    frame_t    shreg;
    baud_div_t div_q;
    dlen_t     dlen_q;
    logic      stop2_q;
    logic      load;
    logic      bit_end;
    logic      shift;

    assign load    = (state == TX_IDLE) && tx_start;
    assign bit_end = (timer == div_q - baud_div_t'(1));
    assign shift   = bit_end && ((state == TX_START) || (state == TX_DATA));
    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge seq) begin
        if (rst) begin
            state       <= TX_IDLE;
            timer       <= '0;
            bit_idx     <= '0;
            stop_second <= 1'b0;
            tx          <= 1'b1;
        end else begin
            // Bit timer restarts at every bit boundary
            if (state == TX_IDLE || bit_end) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    if (tx_start) begin
                        state <= TX_START;
                        tx    <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx      <= shreg[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == dlen_q - dlen_t'(1)) begin
                            state       <= TX_STOP;
                            stop_second <= 1'b0;
                            tx          <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shreg[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (stop2_q && !stop_second) begin
                            stop_second <= 1'b1;
                        end else begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Frame format is frozen for the whole frame
    always_ff @(posedge seq) begin
        if (load) begin
            shreg   <= tx_data;
            div_q   <= baud_div;
            dlen_q  <= dlen;
            stop2_q <= stop2;
        end else if (shift) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

// File: uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic                seq,
    input  logic                rst,
    input  uart_pkg::baud_div_t baud_div,
    input  uart_pkg::dlen_t     dlen,
    input  logic                enable,
    input  logic                rx,
    output logic                rx_busy,
    output logic                rx_valid,
    output uart_pkg::frame_t    rx_data
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    logic      rx_meta;
    logic      rx_sync;
    logic      rx_prev;
    logic      fall;
    baud_div_t timer;
    dlen_t     bit_idx;
    baud_div_t div_q;
    dlen_t     dlen_q;
    frame_t    shreg;
    logic      half_end;
    logic      bit_end;
    logic      step;

    // Two-flop synchronizer, then one more stage for edge detection
    always_ff @(posedge seq) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall     = rx_prev && !rx_sync;
    assign half_end = (timer == (div_q >> 1) - baud_div_t'(1));
    assign bit_end  = (timer == div_q - baud_div_t'(1));
    // Half a period to reach mid start bit, full periods after that
    assign step     = (state == RX_START) ? half_end : bit_end;
    assign rx_busy  = (state != RX_IDLE);

    always_ff @(posedge seq) begin
        if (rst) begin
            state    <= RX_IDLE;
            timer    <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;

            if (state == RX_IDLE || step) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end

            case (state)
                RX_IDLE: begin
                    if (enable && fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (step) begin
                        // Line back high means a glitch, not a start bit
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                        bit_idx <= '0;
                    end
                end
                RX_DATA: begin
                    if (step) begin
                        if (bit_idx == dlen_q - dlen_t'(1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (step) begin
                        state    <= RX_IDLE;
                        rx_valid <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if (state == RX_IDLE && enable && fall) begin
            div_q  <= baud_div;
            dlen_q <= dlen;
        end
        // LSB first, so each new bit enters from the top
        if (state == RX_DATA && step) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        // Short frames sit in the upper bits until realigned here
        if (state == RX_STOP && step) begin
            rx_data <= shreg >> (dlen_t'(8) - dlen_q);
        end
    end

endmodule

// File: uart_regs.sv
`timescale 1ns/10ps

module uart_regs #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  seq,
    input  logic                  rst,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [DATA_WIDTH-1:0] pwdata,
    output logic [DATA_WIDTH-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  pause_req,
    output logic                  pause_ack,
    output logic                  irq,
    output uart_pkg::baud_div_t   baud_div,
    output uart_pkg::dlen_t       dlen,
    output logic                  stop2,
    output logic                  rx_enable,
    output logic                  tx_start,
    output uart_pkg::frame_t      tx_data,
    input  logic                  tx_busy,
    input  logic                  rx_busy,
    input  logic                  rx_valid,
    input  uart_pkg::frame_t      rx_data
);
    import uart_pkg::*;

    offset_t               offset;
    logic                  sel_dr;
    logic                  sel_cr;
    logic                  sel_sr;
    logic                  sel_brr;
    logic                  sel_ier;
    logic                  acc_err;
    logic                  acc_wait;
    logic                  acc_done;
    logic                  dr_wr;
    logic                  dr_rd;
    logic                  cr_wr;
    logic                  brr_wr;
    logic                  ier_wr;
    logic [DATA_WIDTH-1:0] rdata;

    logic                  cr_pe;
    logic                  cr_te;
    logic                  cr_re;
    logic                  cr_stop2;
    dlen_t                 cr_dlen;
    baud_div_t             brr;
    logic [SR_WIDTH-1:0]   ier;
    logic [SR_WIDTH-1:0]   sr;
    frame_t                tx_buf;
    frame_t                rx_buf;
    logic                  tx_go;
    logic                  rx_load;

    // Address decode
    assign offset  = offset_t'(paddr);
    assign sel_dr  = (offset == DR_OFFSET);
    assign sel_cr  = (offset == CR_OFFSET);
    assign sel_sr  = (offset == SR_OFFSET);
    assign sel_brr = (offset == BRR_OFFSET);
    assign sel_ier = (offset == IER_OFFSET);
    assign acc_err = !(sel_dr || sel_cr || sel_sr || sel_brr || sel_ier) || (sel_dr && !cr_pe);

    // First access cycle is the wait state, the second one completes
    assign acc_wait = psel && penable && !pready;
    assign acc_done = psel && penable && pready && !pslverr;
    assign dr_wr    = acc_done && pwrite && sel_dr;
    assign dr_rd    = acc_done && !pwrite && sel_dr;
    assign cr_wr    = acc_done && pwrite && sel_cr;
    assign brr_wr   = acc_done && pwrite && sel_brr;
    assign ier_wr   = acc_done && pwrite && sel_ier;

    always_comb begin
        rdata = '0;
        case (offset)
            DR_OFFSET:  rdata[$bits(frame_t)-1:0] = rx_buf;
            CR_OFFSET: begin
                rdata[CR_PE]                   = cr_pe;
                rdata[CR_TE]                   = cr_te;
                rdata[CR_RE]                   = cr_re;
                rdata[CR_STOP2]                = cr_stop2;
                rdata[CR_DLEN_MSB:CR_DLEN_LSB] = cr_dlen;
            end
            SR_OFFSET:  rdata[SR_WIDTH-1:0] = sr;
            BRR_OFFSET: rdata[$bits(baud_div_t)-1:0] = brr;
            IER_OFFSET: rdata[SR_WIDTH-1:0] = ier;
            default:    rdata = '0;
        endcase
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else if (acc_wait) begin
            pready  <= 1'b1;
            pslverr <= acc_err;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (acc_wait) begin
            prdata <= acc_err ? '0 : rdata;
        end
    end

    // Configuration registers
    always_ff @(posedge seq) begin
        if (rst) begin
            cr_pe    <= 1'b0;
            cr_te    <= 1'b0;
            cr_re    <= 1'b0;
            cr_stop2 <= 1'b0;
            cr_dlen  <= '0;
            brr      <= BRR_RESET;
            ier      <= '0;
        end else begin
            if (cr_wr) begin
                cr_pe    <= pwdata[CR_PE];
                cr_te    <= pwdata[CR_TE];
                cr_re    <= pwdata[CR_RE];
                cr_stop2 <= pwdata[CR_STOP2];
                cr_dlen  <= pwdata[CR_DLEN_MSB:CR_DLEN_LSB];
            end
            if (brr_wr) begin
                brr <= pwdata[$bits(baud_div_t)-1:0];
            end
            if (ier_wr) begin
                ier <= pwdata[SR_WIDTH-1:0];
            end
        end
    end

    // No new frame once a pause is requested or granted
    assign tx_go   = !sr[SR_TBE] && cr_pe && cr_te && !tx_busy && !tx_start
                     && !pause_req && !pause_ack;
    // A DR read on the same edge frees the buffer for the new byte
    assign rx_load = rx_valid && (!sr[SR_RBF] || dr_rd);

    always_ff @(posedge seq) begin
        if (rst) begin
            sr       <= SR_RESET;
            tx_start <= 1'b0;
        end else begin
            tx_start <= tx_go;
            if (tx_start) begin
                sr[SR_TBE] <= 1'b1;
            end
            // A write racing the start pulse leaves the new byte pending
            if (dr_wr) begin
                sr[SR_TBE] <= 1'b0;
            end
            if (dr_rd) begin
                sr[SR_RBF] <= 1'b0;
                sr[SR_OVR] <= 1'b0;
            end
            if (rx_load) begin
                sr[SR_RBF] <= 1'b1;
            end else if (rx_valid) begin
                sr[SR_OVR] <= 1'b1;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (dr_wr) begin
            tx_buf <= pwdata[$bits(frame_t)-1:0];
        end
        if (rx_load) begin
            rx_buf <= rx_data;
        end
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            pause_ack <= 1'b0;
            irq       <= 1'b0;
        end else begin
            // Grant only between frames, hold until the request drops
            pause_ack <= pause_req && (pause_ack || (!tx_busy && !rx_busy && !tx_start));
            irq       <= |(sr & ier);
        end
    end

    assign tx_data   = tx_buf;
    assign baud_div  = brr;
    assign dlen      = cr_dlen;
    assign stop2     = cr_stop2;
    assign rx_enable = cr_pe && cr_re && !pause_ack;

endmodule

// File: uart_periph.sv
`timescale 1ns/10ps

module uart_periph #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  seq,
    input  logic                  rst,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [DATA_WIDTH-1:0] pwdata,
    output logic [DATA_WIDTH-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  pause_req,
    output logic                  pause_ack,
    output logic                  irq,
    output logic                  tx,
    input  logic                  rx
);
    import uart_pkg::*;

    // Engine configuration from the register file
    baud_div_t baud_div;
    dlen_t     dlen;
    logic      stop2;
    logic      rx_enable;

    // Transmit and receive handshakes
    logic      tx_start;
    frame_t    tx_data;
    logic      tx_busy;
    logic      rx_busy;
    logic      rx_valid;
    frame_t    rx_data;

    uart_regs #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_uart_regs (
        .seq       (seq),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .baud_div  (baud_div),
        .dlen      (dlen),
        .stop2     (stop2),
        .rx_enable (rx_enable),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .rx_busy   (rx_busy),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data)
    );

    uart_tx i_uart_tx (
        .seq      (seq),
        .rst      (rst),
        .baud_div (baud_div),
        .dlen     (dlen),
        .stop2    (stop2),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    uart_rx i_uart_rx (
        .seq      (seq),
        .rst      (rst),
        .baud_div (baud_div),
        .dlen     (dlen),
        .enable   (rx_enable),
        .rx       (rx),
        .rx_busy  (rx_busy),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

endmodule

// File: uart_periph_props.sv
`timescale 1ns/10ps

module uart_periph_props (
    input logic seq,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pause_ack,
    input logic tx,
    input logic tx_busy,
    input logic rx_busy
);

    int failures = 0;

    // Completion only inside an access phase
    pready_in_access: assert property (@(posedge seq) disable iff (rst)
        pready |-> (psel && penable))
        else begin
            failures++;
            $error("pready high outside an APB access phase");
        end

    // Grant only once both engines were idle
    pause_grant_idle: assert property (@(posedge seq) disable iff (rst)
        $rose(pause_ack) |-> $past(!tx_busy && !rx_busy))
        else begin
            failures++;
            $error("pause_ack rose while a frame was in flight");
        end

    pause_line_idle: assert property (@(posedge seq) disable iff (rst)
        pause_ack |-> tx)
        else begin
            failures++;
            $error("tx left the idle level while paused");
        end

endmodule

bind uart_periph uart_periph_props i_uart_periph_props (
    .seq       (seq),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pause_ack (pause_ack),
    .tx        (tx),
    .tx_busy   (tx_busy),
    .rx_busy   (rx_busy)
);

// File: uart_tb.sv
`timescale 1ns/10ps

module uart_tb;
    import uart_pkg::*;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int APB_LIMIT  = 16;
    localparam int POLL_LIMIT = 400;
    localparam int PIN_LIMIT  = 2000;

    typedef logic [DATA_WIDTH-1:0] word_t;

    // One row of the register table
    typedef struct packed {
        logic    wr;
        offset_t off;
        word_t   wdata;
        word_t   rdata;
        logic    err;
    } step_t;

    logic                  seq;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  pause_req;
    logic                  pause_ack;
    logic                  irq;
    logic                  line;

    step_t       steps[$];
    logic [15:0] lfsr;
    int          checks;
    int          mismatches;
    int          timeouts;

    // tx looped straight back into rx
    uart_periph #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_uart_periph (
        .seq       (seq),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .tx        (line),
        .rx        (line)
    );

    initial begin
        seq = 1'b0;
        forever #4 seq = ~seq;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_frame(input string name, input frame_t got, input frame_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic random_byte(output frame_t b);
        logic bit_val;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            random_bit(bit_val);
            b = {bit_val, b[7:1]};
        end
    endtask

    // Setup cycle and one wait state before the completing edge
    task automatic apb_access(input logic wr, input offset_t off, input word_t wdata,
                              output word_t rdata, output logic err);
        int count;
        @(negedge seq);
        paddr   = ADDR_WIDTH'(off);
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge seq);
        penable = 1'b1;
        count   = 0;
        @(negedge seq);
        while (!pready && count < APB_LIMIT) begin
            @(negedge seq);
            count++;
        end
        if (pready) begin
            rdata = prdata;
            err   = pslverr;
        end else begin
            timeouts++;
            $display("timeout at %0t: no pready for the access to offset 0x%0h", $time, off);
            rdata = '0;
            err   = 1'b1;
        end
        @(negedge seq);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input offset_t off, input word_t data);
        word_t rd;
        logic  err;
        apb_access(1'b1, off, data, rd, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic apb_read(input offset_t off, output word_t rd);
        logic err;
        apb_access(1'b0, off, '0, rd, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic poll_sr(input int idx, input logic level);
        word_t rd;
        int    count;
        count = 0;
        apb_read(SR_OFFSET, rd);
        while (rd[idx] !== level && count < POLL_LIMIT) begin
            apb_read(SR_OFFSET, rd);
            count++;
        end
        if (rd[idx] !== level) begin
            timeouts++;
            $display("timeout at %0t: SR bit %0d never read %b", $time, idx, level);
        end
    endtask

    function automatic logic output_level(input string name);
        if (name == "irq") begin
            output_level = irq;
        end else if (name == "pause_ack") begin
            output_level = pause_ack;
        end else begin
            output_level = line;
        end
    endfunction

    task automatic wait_output(input string name, input logic level);
        int count;
        count = 0;
        while (output_level(name) !== level && count < PIN_LIMIT) begin
            @(negedge seq);
            count++;
        end
        if (output_level(name) !== level) begin
            timeouts++;
            $display("timeout at %0t: %s never went to %b", $time, name, level);
        end
    endtask

    function automatic step_t make_step(input logic wr, input offset_t off, input word_t wdata,
                                        input word_t rdata, input logic err);
        step_t s;
        s.wr    = wr;
        s.off   = off;
        s.wdata = wdata;
        s.rdata = rdata;
        s.err   = err;
        return s;
    endfunction

    task automatic build_steps();
        // Reset values first
        steps.push_back(make_step(1'b0, BRR_OFFSET, 0, 32'h10, 1'b0));
        steps.push_back(make_step(1'b0, CR_OFFSET, 0, 32'h0, 1'b0));
        steps.push_back(make_step(1'b0, IER_OFFSET, 0, 32'h0, 1'b0));
        steps.push_back(make_step(1'b0, SR_OFFSET, 0, 32'h1, 1'b0));
        // SR ignores writes
        steps.push_back(make_step(1'b1, SR_OFFSET, 32'h6, 0, 1'b0));
        steps.push_back(make_step(1'b0, SR_OFFSET, 0, 32'h1, 1'b0));
        // DR locked while disabled and an unmapped offset
        steps.push_back(make_step(1'b0, DR_OFFSET, 0, 32'h0, 1'b1));
        steps.push_back(make_step(1'b1, DR_OFFSET, 32'h55, 0, 1'b1));
        steps.push_back(make_step(1'b0, SR_OFFSET, 0, 32'h1, 1'b0));
        steps.push_back(make_step(1'b0, 8'h14, 0, 32'h0, 1'b1));
        steps.push_back(make_step(1'b1, 8'h14, 32'h1, 0, 1'b1));
        // Configuration read back with reserved bits 5 and 31 set
        steps.push_back(make_step(1'b1, BRR_OFFSET, 32'h8, 0, 1'b0));
        steps.push_back(make_step(1'b0, BRR_OFFSET, 0, 32'h8, 1'b0));
        steps.push_back(make_step(1'b1, CR_OFFSET, 32'h0807, 0, 1'b0));
        steps.push_back(make_step(1'b0, CR_OFFSET, 0, 32'h0807, 1'b0));
        steps.push_back(make_step(1'b1, CR_OFFSET, 32'h8000_0827, 0, 1'b0));
        steps.push_back(make_step(1'b0, CR_OFFSET, 0, 32'h0807, 1'b0));
        steps.push_back(make_step(1'b1, IER_OFFSET, 32'h7, 0, 1'b0));
        steps.push_back(make_step(1'b0, IER_OFFSET, 0, 32'h7, 1'b0));
        steps.push_back(make_step(1'b1, IER_OFFSET, 32'h0, 0, 1'b0));
        steps.push_back(make_step(1'b0, IER_OFFSET, 0, 32'h0, 1'b0));
    endtask

    task automatic run_loopback(input word_t cr_value, input frame_t mask);
        frame_t sent[$];
        frame_t b;
        logic   two;
        word_t  rd;
        apb_write(CR_OFFSET, cr_value);
        for (int r = 0; r < 10; r++) begin
            sent.delete();
            random_bit(two);
            for (int k = 0; k <= int'(two); k++) begin
                random_byte(b);
                poll_sr(SR_TBE, 1'b1);
                apb_write(DR_OFFSET, word_t'(b));
                sent.push_back(b);
            end
            foreach (sent[k]) begin
                poll_sr(SR_RBF, 1'b1);
                apb_read(DR_OFFSET, rd);
                check_frame("rx byte", rd[7:0], sent[k] & mask);
            end
        end
    endtask

    initial begin
        step_t  s;
        word_t  rd;
        logic   err;
        frame_t b0;
        frame_t b1;
        frame_t b2;
        int     assert_fails;

        rst        = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        pause_req  = 1'b0;
        lfsr       = 16'd25;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        repeat (10) @(posedge seq);
        @(negedge seq);
        rst = 1'b0;

        build_steps();
        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            apb_access(s.wr, s.off, s.wdata, rd, err);
            check_bit($sformatf("pslverr step %0d", i), err, s.err);
            if (!s.wr) begin
                check_word($sformatf("prdata step %0d", i), rd, s.rdata);
            end
        end

        // Interrupt follows IER with TBE set
        repeat (2) @(negedge seq);
        check_bit("irq", irq, 1'b0);
        apb_write(IER_OFFSET, word_t'(1) << SR_TBE);
        wait_output("irq", 1'b1);
        apb_write(IER_OFFSET, '0);
        wait_output("irq", 1'b0);

        run_loopback(32'h0807, 8'hFF);
        // Five data bits and two stop bits
        run_loopback(32'h0517, 8'h1F);

        // Overrun keeps the first byte
        apb_write(CR_OFFSET, 32'h0807);
        random_byte(b0);
        random_byte(b1);
        random_byte(b2);
        poll_sr(SR_TBE, 1'b1);
        apb_write(DR_OFFSET, word_t'(b0));
        poll_sr(SR_TBE, 1'b1);
        apb_write(DR_OFFSET, word_t'(b1));
        poll_sr(SR_OVR, 1'b1);
        poll_sr(SR_TBE, 1'b1);
        apb_write(DR_OFFSET, word_t'(b2));
        apb_read(SR_OFFSET, rd);
        check_bit("sr ovr", rd[SR_OVR], 1'b1);
        apb_read(DR_OFFSET, rd);
        check_frame("rx byte after overrun", rd[7:0], b0);
        apb_read(SR_OFFSET, rd);
        check_word("sr rbf and ovr", rd & ((word_t'(1) << SR_RBF) | (word_t'(1) << SR_OVR)), '0);
        poll_sr(SR_RBF, 1'b1);
        apb_read(DR_OFFSET, rd);
        check_frame("rx byte after overrun", rd[7:0], b2);

        // Pause requested in the middle of a frame
        random_byte(b0);
        random_byte(b1);
        poll_sr(SR_TBE, 1'b1);
        apb_write(DR_OFFSET, word_t'(b0));
        wait_output("tx", 1'b0);
        @(negedge seq);
        pause_req = 1'b1;
        @(negedge seq);
        check_bit("pause_ack", pause_ack, 1'b0);
        wait_output("pause_ack", 1'b1);
        apb_read(SR_OFFSET, rd);
        check_bit("sr rbf at pause grant", rd[SR_RBF], 1'b1);
        apb_read(DR_OFFSET, rd);
        check_frame("rx byte before pause", rd[7:0], b0);
        apb_write(DR_OFFSET, word_t'(b1));
        // Two frame times with nothing on the line
        repeat (200) @(negedge seq);
        apb_read(SR_OFFSET, rd);
        check_bit("sr rbf while paused", rd[SR_RBF], 1'b0);
        check_bit("sr tbe while paused", rd[SR_TBE], 1'b0);
        check_bit("pause_ack", pause_ack, 1'b1);
        @(negedge seq);
        pause_req = 1'b0;
        wait_output("pause_ack", 1'b0);
        poll_sr(SR_RBF, 1'b1);
        apb_read(DR_OFFSET, rd);
        check_frame("rx byte after pause", rd[7:0], b1);

        assert_fails = i_uart_periph.i_uart_periph_props.failures;
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 checks, mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_periph.sv
uart_periph_props.sv
uart_tb.sv

// File: Bender.yml
package:
  name: uart_periph

sources:
  - uart_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_regs.sv
  - uart_periph.sv
  - target: test
    files:
      - uart_periph_props.sv
      - uart_tb.sv
